// ==== project.f ====
rtl/rtos_cfg_pkg.sv
rtl/rtos_if_pkg.sv
rtl/cold_regfile.sv
rtl/task_sched.sv
rtl/ctx_mem_port.sv
rtl/ctx_ctrl.sv
rtl/rtos_ctx_top.sv
verif/tb_clkgen.sv
verif/rtos_ctx_sva.sv
verif/tb_rtos_ctx.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rtos_ctx
FILELIST ?= project.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), pass or fail from $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^All checks passed$$" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/tb_rtos_ctx.sv ====
`timescale 1ns/1ps

module tb_rtos_ctx;
    import rtos_cfg_pkg::*;
    import rtos_if_pkg::*;

    localparam int NUM_TASKS     = 8;
    localparam int NUM_COLD_REGS = 8;
    localparam int RIDX_W        = $clog2(NUM_COLD_REGS);
    localparam int FW            = NUM_COLD_REGS + CSR_WORDS;  // words per frame
    localparam int MEM_WORDS     = 128;
    localparam int ROUNDS        = 20;
    localparam int ROUND_CYCLES  = 160;  // ~90 for the switch, rest for round stimulus
    localparam int LIMIT         = ROUNDS * ROUND_CYCLES + 500;

    logic                  clk;
    logic                  rst_n;
    logic [REG_ADDR_W-1:0] raddr_i;
    logic [XLEN-1:0]       rdata_o;
    rf_wr_t                wr_i;
    logic                  we_i;
    logic                  trap_i;
    trap_csr_t             trap_csr_i;
    logic                  mret_i;
    logic                  mret_ready_o;
    logic                  busy_o;
    trap_csr_t             restore_o;
    logic                  restore_valid_o;
    logic                  inst_en_i;
    cust_inst_t            inst_i;
    logic [XLEN-1:0]       inst_rd_o;
    logic                  inst_done_o;
    mem_req_t              mem_req_o;
    logic                  mem_valid_o;
    logic                  mem_ready_i;
    logic                  mem_rvalid_i;
    logic [XLEN-1:0]       mem_rdata_i;

    // memory and kernel model
    logic [XLEN-1:0]       mem [MEM_WORDS];
    logic [XLEN-1:0]       regs_m [NUM_COLD_REGS];
    logic [XLEN-1:0]       frame_m [NUM_TASKS][FW];
    logic [NUM_TASKS-1:0]  vld_m;
    logic [PRIO_W-1:0]     prio_m [NUM_TASKS];
    logic [TASK_ID_W-1:0]  cur_m;

    logic [15:0] stim_lfsr = 16'd13380;  // register data, table ops, csr values
    logic [15:0] mem_lfsr  = 16'd13380;  // ready gaps and read latency
    int          word_errs = 0;
    int          csr_errs  = 0;
    int          id_errs   = 0;
    int          fault_errs = 0;
    int          cycles    = 0;
    int          total;

    tb_clkgen clkgen0 (.clk_o(clk), .rst_n_o(rst_n));

    rtos_ctx_top #(.NUM_TASKS(NUM_TASKS), .NUM_COLD_REGS(NUM_COLD_REGS)) dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .raddr_i, .rdata_o, .wr_i, .we_i, .trap_i, .trap_csr_i,
        .mret_i, .mret_ready_o, .busy_o, .restore_o, .restore_valid_o, .inst_en_i, .inst_i,
        .inst_rd_o, .inst_done_o, .mem_req_o, .mem_valid_o, .mem_ready_i, .mem_rvalid_i,
        .mem_rdata_i
    );

    // galois form, x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);  // one step per bit
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            mem_lfsr = lfsr_next(mem_lfsr);
            v = {v[30:0], mem_lfsr[0]};
        end
        return v;
    endfunction

    // highest priority first, then the lowest id among equals
    function automatic logic [TASK_ID_W-1:0] pick_next();
        int                   top;
        logic [TASK_ID_W-1:0] pick;
        top  = -1;
        pick = cur_m;  // none ready, current runs again
        for (int t = 0; t < NUM_TASKS; t++) begin
            if (vld_m[t] && int'(prio_m[t]) > top) top = int'(prio_m[t]);
        end
        for (int t = NUM_TASKS - 1; t >= 0; t--) begin
            if (vld_m[t] && int'(prio_m[t]) == top) pick = TASK_ID_W'(t);
        end
        return pick;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            word_errs++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_csr(input string name, input trap_csr_t exp, input trap_csr_t act);
        if (act !== exp) begin
            csr_errs++;
            $display("[ERROR] %s expected mepc %h mstatus %h actual mepc %h mstatus %h",
                     name, exp.mepc, exp.mstatus, act.mepc, act.mstatus);
        end
    endtask

    task automatic check_id(input string name, input logic [TASK_ID_W-1:0] exp,
                            input logic [TASK_ID_W-1:0] act);
        if (act !== exp) begin
            id_errs++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report_fault(input string what);
        fault_errs++;
        $display("%s", what);
    endtask

    // each task starts and ends 1 ns past a rising edge
    task automatic write_reg(input logic [REG_ADDR_W-1:0] a, input logic [XLEN-1:0] d);
        we_i    = 1'b1;
        wr_i    = '{addr: a, data: d};
        @(posedge clk);
        #1;
        we_i = 1'b0;
        if (int'(a) < NUM_COLD_REGS) regs_m[a[RIDX_W-1:0]] = d;  // above range is dropped
    endtask

    task automatic read_check(input logic [REG_ADDR_W-1:0] a, input string tag);
        logic [XLEN-1:0] exp;
        exp     = (int'(a) < NUM_COLD_REGS) ? regs_m[a[RIDX_W-1:0]] : '0;
        raddr_i = a;
        @(negedge clk);  // comb read settled
        check_word($sformatf("%s reg %0d", tag, a), exp, rdata_o);
        @(posedge clk);
        #1;
    endtask

    task automatic exec_inst(input cust_op_e op, input logic [TASK_ID_W-1:0] id,
                             input logic [PRIO_W-1:0] p);
        logic [XLEN-1:0] exp;
        exp = '0;
        case (op)
            OP_CREATE: begin
                if (int'(id) < NUM_TASKS) begin
                    vld_m[id]  = 1'b1;
                    prio_m[id] = p;
                    exp        = XLEN'(1);
                end
            end
            OP_DELETE: if (int'(id) < NUM_TASKS) vld_m[id] = 1'b0;
            default: exp = XLEN'(cur_m);
        endcase
        inst_en_i = 1'b1;
        inst_i    = '{funct3: op, id: id, prio: p};
        @(posedge clk);
        #1;
        inst_en_i = 1'b0;
        @(negedge clk);
        if (inst_done_o !== 1'b1) report_fault("inst_done_o did not follow inst_en_i by one cycle");
        if (op == OP_GET_CUR) check_id("get_cur id", cur_m, inst_rd_o[TASK_ID_W-1:0]);
        check_word($sformatf("inst %s id %0d", op.name(), id), exp, inst_rd_o);
        @(posedge clk);
        #1;
    endtask

    task automatic random_inst();
        logic [1:0] k;
        cust_op_e   op;
        k = 2'(stim_bits(2));
        case (k)
            2'd2:    op = OP_DELETE;
            2'd3:    op = OP_GET_CUR;
            default: op = OP_CREATE;  // creates weighted so the table fills
        endcase
        exec_inst(op, TASK_ID_W'(stim_bits(TASK_ID_W)), PRIO_W'(stim_bits(PRIO_W)));
    endtask

    task automatic trap_round(input int r);
        trap_csr_t            csr;
        trap_csr_t            exp_csr;
        logic [TASK_ID_W-1:0] old_id;
        logic [TASK_ID_W-1:0] nxt;
        csr.mepc    = stim_bits(32);
        csr.mstatus = stim_bits(32);
        old_id      = cur_m;
        // frame the model expects to find in memory
        for (int i = 0; i < NUM_COLD_REGS; i++) frame_m[old_id][i] = regs_m[i];
        frame_m[old_id][NUM_COLD_REGS]     = csr.mepc;
        frame_m[old_id][NUM_COLD_REGS + 1] = csr.mstatus;
        nxt             = pick_next();
        exp_csr.mepc    = frame_m[nxt][NUM_COLD_REGS];
        exp_csr.mstatus = frame_m[nxt][NUM_COLD_REGS + 1];

        trap_i     = 1'b1;
        trap_csr_i = csr;
        @(posedge clk);
        #1;
        trap_i = 1'b0;
        mret_i = 1'b1;  // core parks on its return
        while (restore_valid_o !== 1'b1) begin
            we_i = 1'b1;  // stray writes, must be dropped
            wr_i = '{addr: REG_ADDR_W'(stim_bits(RIDX_W)), data: stim_bits(32)};
            @(negedge clk);
            if (busy_o !== 1'b1 || mret_ready_o !== 1'b0)
                report_fault($sformatf("round %0d: DUT stopped stalling before restore", r));
            @(posedge clk);
            #1;
        end
        we_i = 1'b0;
        @(negedge clk);
        check_csr($sformatf("round %0d restore", r), exp_csr, restore_o);
        if (mret_ready_o !== 1'b1)
            report_fault($sformatf("round %0d: mret_ready_o low in the restore cycle", r));
        @(posedge clk);
        #1;
        mret_i = 1'b0;

        for (int w = 0; w < FW; w++) begin
            check_word($sformatf("round %0d save task %0d word %0d", r, old_id, w),
                       frame_m[old_id][w], mem[int'(old_id) * FW + w]);
        end
        cur_m = nxt;
        for (int i = 0; i < NUM_COLD_REGS; i++) regs_m[i] = frame_m[nxt][i];
        for (int i = 0; i < NUM_COLD_REGS; i++) begin
            read_check(REG_ADDR_W'(i), $sformatf("round %0d restored", r));
        end
        exec_inst(OP_GET_CUR, '0, '0);
    endtask

    // context memory, ready gaps and 0..3 cycle read latency
    initial begin : mem_model
        logic       rd_pend;
        int         rd_wait;
        int         rd_idx;
        int         idx;
        logic [1:0] lat;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;
        rd_pend      = 1'b0;
        rd_wait      = 0;
        rd_idx       = 0;
        mem_ready_i  = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready_i  = 1'b0;
            mem_rvalid_i = 1'b0;
            idx          = int'(mem_req_o.addr >> 2);
            if (rd_pend) begin
                if (rd_wait == 0) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = mem[rd_idx];
                    rd_pend      = 1'b0;
                end else begin
                    rd_wait--;
                end
            end else if (mem_valid_o === 1'b1 && mem_bits(2) != 0) begin  // 1 in 4 stalls
                mem_ready_i = 1'b1;
                if (mem_req_o.we) begin
                    mem[idx] = mem_req_o.wdata;
                end else begin
                    lat = 2'(mem_bits(2));
                    if (lat == 2'd0) begin
                        mem_rvalid_i = 1'b1;  // data in the accept cycle
                        mem_rdata_i  = mem[idx];
                    end else begin
                        rd_pend = 1'b1;
                        rd_wait = int'(lat) - 1;
                        rd_idx  = idx;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        raddr_i    = '0;
        wr_i       = '0;
        we_i       = 1'b0;
        trap_i     = 1'b0;
        trap_csr_i = '0;
        mret_i     = 1'b0;
        inst_en_i  = 1'b0;
        inst_i     = '0;
        vld_m      = '0;
        cur_m      = '0;
        for (int i = 0; i < NUM_COLD_REGS; i++) regs_m[i] = '0;
        for (int t = 0; t < NUM_TASKS; t++) begin
            prio_m[t] = '0;
            for (int w = 0; w < FW; w++) frame_m[t][w] = '0;  // memory starts zeroed
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;

        // register bank, out of range pokes then a full sweep
        for (int i = 0; i < NUM_COLD_REGS; i++) write_reg(REG_ADDR_W'(i), stim_bits(32));
        for (int i = 0; i < 4; i++) begin
            write_reg(REG_ADDR_W'(NUM_COLD_REGS + int'(stim_bits(4))), stim_bits(32));
        end
        for (int a = 0; a < (1 << REG_ADDR_W); a++) read_check(REG_ADDR_W'(a), "sweep");

        for (int i = 0; i < 16; i++) random_inst();

        for (int r = 0; r < ROUNDS; r++) begin
            for (int i = 0; i < NUM_COLD_REGS; i++) write_reg(REG_ADDR_W'(i), stim_bits(32));
            random_inst();
            trap_round(r);
        end

        total = word_errs + csr_errs + id_errs + fault_errs;
        $display("errors: word %0d, csr %0d, id %0d, other %0d",
                 word_errs, csr_errs, id_errs, fault_errs);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verif/rtos_ctx_sva.sv ====
`timescale 1ns/1ps

module rtos_ctx_sva (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input rtos_if_pkg::mem_req_t req_i,
    input logic                  valid_i,
    input logic                  ready_i,
    input logic                  rvalid_i,
    input logic                  busy_i,
    input logic                  restore_valid_i
);
    logic rd_open_q;  // read accepted, data not back yet

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_open_q <= 1'b0;
        end else if (rvalid_i) begin
            rd_open_q <= 1'b0;  // zero latency return closes it at once
        end else if (valid_i && ready_i && !req_i.we) begin
            rd_open_q <= 1'b1;
        end
    end

    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i && $stable(req_i))
        else $error("memory request changed or dropped under back-pressure");

    one_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_open_q |-> !(valid_i && !req_i.we))
        else $error("second read issued before the first one returned");

    busy_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(busy_i) |-> restore_valid_i)
        else $error("busy fell without a restore pulse");

endmodule

// top holds both the memory port and the trap controller outputs
bind rtos_ctx_top rtos_ctx_sva sva0 (
    .clk_i, .rst_n_i, .req_i(mem_req_o), .valid_i(mem_valid_o), .ready_i(mem_ready_i),
    .rvalid_i(mem_rvalid_i), .busy_i(busy_o), .restore_valid_i(restore_valid_o)
);

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_NS    = 4,  // 8 ns period
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;  // release off the edge
    end

endmodule

// ==== rtl/rtos_ctx_top.sv ====
`timescale 1ns/1ps

module rtos_ctx_top #(
    parameter int NUM_TASKS     = 8,
    parameter int NUM_COLD_REGS = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // cold register port
    input  logic [rtos_cfg_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [rtos_cfg_pkg::XLEN-1:0]       rdata_o,
    input  rtos_if_pkg::rf_wr_t                 wr_i,
    input  logic                                we_i,
    // trap and return
    input  logic                                trap_i,
    input  rtos_if_pkg::trap_csr_t              trap_csr_i,
    input  logic                                mret_i,
    output logic                                mret_ready_o,
    output logic                                busy_o,
    output rtos_if_pkg::trap_csr_t              restore_o,
    output logic                                restore_valid_o,
    // custom instructions
    input  logic                                inst_en_i,
    input  rtos_if_pkg::cust_inst_t             inst_i,
    output logic [rtos_cfg_pkg::XLEN-1:0]       inst_rd_o,
    output logic                                inst_done_o,
    // context memory
    output rtos_if_pkg::mem_req_t               mem_req_o,
    output logic                                mem_valid_o,
    input  logic                                mem_ready_i,
    input  logic                                mem_rvalid_i,
    input  logic [rtos_cfg_pkg::XLEN-1:0]       mem_rdata_i
);
    import rtos_cfg_pkg::*;
    import rtos_if_pkg::*;

    localparam int IDX_W = $clog2(frame_words(NUM_COLD_REGS));

    logic [TASK_ID_W-1:0]  cur_id;
    logic [TASK_ID_W-1:0]  next_id;
    logic                  sel_go;
    logic                  sel_done;
    logic                  word_go;
    logic                  word_we;
    logic [IDX_W-1:0]      word_idx;
    logic [TASK_ID_W-1:0]  word_task;
    logic [XLEN-1:0]       word_wdata;
    logic                  word_done;
    logic [XLEN-1:0]       word_rdata;
    logic [REG_ADDR_W-1:0] rf_raddr;
    logic [XLEN-1:0]       rf_rdata;
    rf_wr_t                rf_wr;
    logic                  rf_we;

    assign mret_ready_o = ~busy_o;  // mret stalls while a switch runs

    ctx_ctrl #(.NUM_COLD_REGS(NUM_COLD_REGS)) ctrl0 (
        .clk_i, .rst_n_i, .trap_i, .trap_csr_i, .busy_o, .restore_o, .restore_valid_o,
        .cur_id_o(cur_id), .next_id_i(next_id), .sel_go_o(sel_go), .sel_done_i(sel_done),
        .word_go_o(word_go), .word_we_o(word_we), .word_idx_o(word_idx),
        .word_task_o(word_task), .word_wdata_o(word_wdata), .word_done_i(word_done),
        .word_rdata_i(word_rdata), .rf_raddr_o(rf_raddr), .rf_rdata_i(rf_rdata),
        .rf_wr_o(rf_wr), .rf_we_o(rf_we)
    );

    task_sched #(.NUM_TASKS(NUM_TASKS)) sched0 (
        .clk_i, .rst_n_i, .inst_en_i, .inst_i, .inst_rd_o, .inst_done_o,
        .cur_id_i(cur_id), .sel_go_i(sel_go), .sel_done_o(sel_done), .next_id_o(next_id)
    );

    cold_regfile #(.NUM_COLD_REGS(NUM_COLD_REGS)) rf0 (
        .clk_i, .rst_n_i, .raddr_i, .rdata_o, .wr_i, .we_i,
        .ctl_raddr_i(rf_raddr), .ctl_rdata_o(rf_rdata), .ctl_wr_i(rf_wr), .ctl_we_i(rf_we),
        .busy_i(busy_o)
    );

    ctx_mem_port #(.NUM_COLD_REGS(NUM_COLD_REGS)) mem0 (
        .clk_i, .rst_n_i, .word_go_i(word_go), .word_we_i(word_we), .word_idx_i(word_idx),
        .word_task_i(word_task), .word_wdata_i(word_wdata), .word_done_o(word_done),
        .word_rdata_o(word_rdata), .mem_req_o, .mem_valid_o, .mem_ready_i, .mem_rvalid_i,
        .mem_rdata_i
    );

endmodule

// ==== rtl/ctx_ctrl.sv ====
`timescale 1ns/1ps

module ctx_ctrl #(
    parameter int  NUM_COLD_REGS = 8,
    localparam int FRAME_WORDS   = rtos_cfg_pkg::frame_words(NUM_COLD_REGS),
    localparam int IDX_W         = $clog2(FRAME_WORDS)
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // core trap side
    input  logic                                trap_i,
    input  rtos_if_pkg::trap_csr_t              trap_csr_i,
    output logic                                busy_o,
    output rtos_if_pkg::trap_csr_t              restore_o,
    output logic                                restore_valid_o,
    // scheduler
    output logic [rtos_cfg_pkg::TASK_ID_W-1:0]  cur_id_o,
    input  logic [rtos_cfg_pkg::TASK_ID_W-1:0]  next_id_i,
    output logic                                sel_go_o,
    input  logic                                sel_done_i,
    // memory port
    output logic                                word_go_o,
    output logic                                word_we_o,
    output logic [IDX_W-1:0]                    word_idx_o,
    output logic [rtos_cfg_pkg::TASK_ID_W-1:0]  word_task_o,
    output logic [rtos_cfg_pkg::XLEN-1:0]       word_wdata_o,
    input  logic                                word_done_i,
    input  logic [rtos_cfg_pkg::XLEN-1:0]       word_rdata_i,
    // register bank
    output logic [rtos_cfg_pkg::REG_ADDR_W-1:0] rf_raddr_o,
    input  logic [rtos_cfg_pkg::XLEN-1:0]       rf_rdata_i,
    output rtos_if_pkg::rf_wr_t                 rf_wr_o,
    output logic                                rf_we_o
);
    import rtos_cfg_pkg::*;
    import rtos_if_pkg::*;

    typedef enum logic [2:0] {IDLE, SAVE, SELECT, LOAD, DONE} ctx_st_e;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_WORDS - 1);

    ctx_st_e              st_q;
    logic                 wait_q;    // word or search in flight
    logic [IDX_W-1:0]     idx_q;     // frame word being moved
    logic [TASK_ID_W-1:0] cur_id_q;
    logic [TASK_ID_W-1:0] nxt_id_q;  // picked task, loaded from
    trap_csr_t            csr_q;     // trapped mepc/mstatus
    trap_csr_t            restore_q;
    logic                 accept;
    logic                 is_cold;   // word lives in the register bank
    logic                 is_mepc;
    logic                 is_mstat;
    logic                 last_word;

    assign busy_o          = st_q inside {SAVE, SELECT, LOAD};  // low again in DONE
    assign restore_valid_o = (st_q == DONE);
    assign restore_o       = restore_q;
    assign cur_id_o        = cur_id_q;
    assign accept          = trap_i && !busy_o;

    assign is_cold   = int'(idx_q) < NUM_COLD_REGS;
    assign is_mepc   = int'(idx_q) == NUM_COLD_REGS + MEPC_OFS;
    assign is_mstat  = int'(idx_q) == NUM_COLD_REGS + MSTATUS_OFS;
    assign last_word = (idx_q == LAST_IDX);

    // one go per word, then wait for done
    assign word_go_o    = (st_q == SAVE || st_q == LOAD) && !wait_q;
    assign word_we_o    = (st_q == SAVE);
    assign word_idx_o   = idx_q;
    assign word_task_o  = (st_q == SAVE) ? cur_id_q : nxt_id_q;
    assign word_wdata_o = is_cold ? rf_rdata_i : (is_mepc ? csr_q.mepc : csr_q.mstatus);
    assign sel_go_o     = (st_q == SELECT) && !wait_q;

    // bank read for save, bank write as load data returns
    assign rf_raddr_o   = REG_ADDR_W'(idx_q);
    assign rf_wr_o.addr = REG_ADDR_W'(idx_q);
    assign rf_wr_o.data = word_rdata_i;
    assign rf_we_o      = (st_q == LOAD) && word_done_i && is_cold;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st_q     <= IDLE;
            wait_q   <= 1'b0;
            idx_q    <= '0;
            cur_id_q <= '0;
        end else begin
            case (st_q)
                IDLE, DONE: begin
                    st_q   <= accept ? SAVE : IDLE;  // back to back trap from DONE
                    idx_q  <= '0;
                    wait_q <= 1'b0;
                end
                SAVE, LOAD: begin
                    if (word_go_o) wait_q <= 1'b1;
                    if (word_done_i) begin
                        wait_q <= 1'b0;
                        idx_q  <= last_word ? '0 : idx_q + 1'b1;
                        if (last_word) begin
                            st_q <= (st_q == SAVE) ? SELECT : DONE;
                            if (st_q == LOAD) cur_id_q <= nxt_id_q;  // switch takes effect
                        end
                    end
                end
                SELECT: begin
                    if (sel_go_o) wait_q <= 1'b1;
                    if (sel_done_i) begin
                        wait_q <= 1'b0;
                        st_q   <= LOAD;
                    end
                end
                default: st_q <= IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk_i) begin
        if (accept) csr_q <= trap_csr_i;
        if (sel_done_i) nxt_id_q <= next_id_i;
        if (st_q == LOAD && word_done_i) begin
            if (is_mepc) restore_q.mepc <= word_rdata_i;
            if (is_mstat) restore_q.mstatus <= word_rdata_i;
        end
    end

endmodule

// ==== rtl/ctx_mem_port.sv ====
`timescale 1ns/1ps

module ctx_mem_port #(
    parameter int  NUM_COLD_REGS = 8,
    localparam int FRAME_WORDS   = rtos_cfg_pkg::frame_words(NUM_COLD_REGS),
    localparam int IDX_W         = $clog2(FRAME_WORDS)
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    // word access from the controller
    input  logic                               word_go_i,
    input  logic                               word_we_i,
    input  logic [IDX_W-1:0]                   word_idx_i,
    input  logic [rtos_cfg_pkg::TASK_ID_W-1:0] word_task_i,
    input  logic [rtos_cfg_pkg::XLEN-1:0]      word_wdata_i,
    output logic                               word_done_o,
    output logic [rtos_cfg_pkg::XLEN-1:0]      word_rdata_o,
    // context memory
    output rtos_if_pkg::mem_req_t              mem_req_o,
    output logic                               mem_valid_o,
    input  logic                               mem_ready_i,
    input  logic                               mem_rvalid_i,
    input  logic [rtos_cfg_pkg::XLEN-1:0]      mem_rdata_i
);
    import rtos_cfg_pkg::*;

    typedef enum logic [1:0] {P_IDLE, P_REQ, P_RESP} port_st_e;

    port_st_e          st_q;
    logic [ADDR_W-1:0] word_addr;
    logic              rd_ret;  // read data arrives this cycle

    // task frame base plus word offset, in bytes
    assign word_addr = (ADDR_W'(word_task_i) * ADDR_W'(FRAME_WORDS) + ADDR_W'(word_idx_i))
                       << WORD_SHIFT;
    assign mem_valid_o = (st_q == P_REQ);
    // zero latency read may come back in the accept cycle
    assign rd_ret = mem_rvalid_i &&
                    (st_q == P_RESP || (st_q == P_REQ && mem_ready_i && !mem_req_o.we));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st_q        <= P_IDLE;
            word_done_o <= 1'b0;
        end else begin
            word_done_o <= 1'b0;
            case (st_q)
                P_IDLE: if (word_go_i) st_q <= P_REQ;
                P_REQ: begin
                    if (mem_ready_i) begin
                        st_q        <= (mem_req_o.we || rd_ret) ? P_IDLE : P_RESP;
                        word_done_o <= mem_req_o.we || rd_ret;  // writes end at accept
                    end
                end
                P_RESP: begin
                    if (rd_ret) begin
                        st_q        <= P_IDLE;
                        word_done_o <= 1'b1;
                    end
                end
                default: st_q <= P_IDLE;
            endcase
        end
    end

    // request held stable until accepted
    always_ff @(posedge clk_i) begin
        if (st_q == P_IDLE && word_go_i) begin
            mem_req_o.addr  <= word_addr;
            mem_req_o.wdata <= word_wdata_i;
            mem_req_o.we    <= word_we_i;
        end
        if (rd_ret) word_rdata_o <= mem_rdata_i;
    end

endmodule

// ==== rtl/task_sched.sv ====
`timescale 1ns/1ps

module task_sched #(
    parameter int NUM_TASKS = 8
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               inst_en_i,
    input  rtos_if_pkg::cust_inst_t            inst_i,
    output logic [rtos_cfg_pkg::XLEN-1:0]      inst_rd_o,
    output logic                               inst_done_o,
    input  logic [rtos_cfg_pkg::TASK_ID_W-1:0] cur_id_i,
    input  logic                               sel_go_i,
    output logic                               sel_done_o,
    output logic [rtos_cfg_pkg::TASK_ID_W-1:0] next_id_o
);
    import rtos_cfg_pkg::*;

    logic [NUM_TASKS-1:0] vld_q;             // task ready bits
    logic [PRIO_W-1:0]    prio_q [NUM_TASKS];
    logic                 id_ok;             // id fits the table
    logic                 best_hit;
    logic [TASK_ID_W-1:0] best_id;
    logic [PRIO_W-1:0]    best_prio;

    assign id_ok = int'(inst_i.id) < NUM_TASKS;

    // valid bits and done strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld_q       <= '0;
            inst_done_o <= 1'b0;
            sel_done_o  <= 1'b0;
        end else begin
            inst_done_o <= inst_en_i;  // fixed one cycle
            sel_done_o  <= sel_go_i;
            if (inst_en_i && id_ok) begin
                if (inst_i.funct3 == OP_CREATE) vld_q[inst_i.id] <= 1'b1;
                if (inst_i.funct3 == OP_DELETE) vld_q[inst_i.id] <= 1'b0;
            end
        end
    end

    // priorities, instruction result and picked id
    always_ff @(posedge clk_i) begin
        if (inst_en_i) begin
            inst_rd_o <= '0;
            case (inst_i.funct3)
                OP_CREATE: begin
                    if (id_ok) begin
                        prio_q[inst_i.id] <= inst_i.prio;
                        inst_rd_o         <= XLEN'(1);
                    end
                end
                OP_GET_CUR: inst_rd_o <= XLEN'(cur_id_i);
                default: inst_rd_o <= '0;  // delete and unknown codes
            endcase
        end
        if (sel_go_i) next_id_o <= best_id;
    end

    // linear search, strict compare keeps the lowest id on ties
    always_comb begin
        best_hit  = 1'b0;
        best_id   = cur_id_i;  // nothing ready, stay put
        best_prio = '0;
        for (int i = 0; i < NUM_TASKS; i++) begin
            if (vld_q[i] && (!best_hit || prio_q[i] > best_prio)) begin
                best_hit  = 1'b1;
                best_id   = TASK_ID_W'(i);
                best_prio = prio_q[i];
            end
        end
    end

endmodule

// ==== rtl/cold_regfile.sv ====
`timescale 1ns/1ps

module cold_regfile #(
    parameter int NUM_COLD_REGS = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // core side
    input  logic [rtos_cfg_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [rtos_cfg_pkg::XLEN-1:0]       rdata_o,
    input  rtos_if_pkg::rf_wr_t                 wr_i,
    input  logic                                we_i,
    // controller side, used during save and load
    input  logic [rtos_cfg_pkg::REG_ADDR_W-1:0] ctl_raddr_i,
    output logic [rtos_cfg_pkg::XLEN-1:0]       ctl_rdata_o,
    input  rtos_if_pkg::rf_wr_t                 ctl_wr_i,
    input  logic                                ctl_we_i,
    input  logic                                busy_i
);
    import rtos_cfg_pkg::*;

    localparam int RIDX_W = $clog2(NUM_COLD_REGS);

    logic [XLEN-1:0] regs_q [NUM_COLD_REGS];

    // out of range reads give zero
    assign rdata_o     = (int'(raddr_i) < NUM_COLD_REGS) ? regs_q[raddr_i[RIDX_W-1:0]] : '0;
    assign ctl_rdata_o = (int'(ctl_raddr_i) < NUM_COLD_REGS) ?
                         regs_q[ctl_raddr_i[RIDX_W-1:0]] : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_COLD_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (we_i && !busy_i && int'(wr_i.addr) < NUM_COLD_REGS) begin  // frozen mid switch
                regs_q[wr_i.addr[RIDX_W-1:0]] <= wr_i.data;
            end
            // restore write last so it wins a same-address clash
            if (ctl_we_i && int'(ctl_wr_i.addr) < NUM_COLD_REGS) begin
                regs_q[ctl_wr_i.addr[RIDX_W-1:0]] <= ctl_wr_i.data;
            end
        end
    end

endmodule

// ==== rtl/rtos_if_pkg.sv ====
package rtos_if_pkg;

    // csr pair taken on trap, handed back on restore
    typedef struct packed {
        logic [rtos_cfg_pkg::XLEN-1:0] mepc;
        logic [rtos_cfg_pkg::XLEN-1:0] mstatus;
    } trap_csr_t;

    // decoded custom instruction from the core
    typedef struct packed {
        rtos_cfg_pkg::cust_op_e             funct3;
        logic [rtos_cfg_pkg::TASK_ID_W-1:0] id;    // low bits of rs1
        logic [rtos_cfg_pkg::PRIO_W-1:0]    prio;  // low bits of rs2, create only
    } cust_inst_t;

    // one word access toward context memory
    typedef struct packed {
        logic [rtos_cfg_pkg::ADDR_W-1:0] addr;   // byte address
        logic [rtos_cfg_pkg::XLEN-1:0]   wdata;  // don't care on reads
        logic                            we;
    } mem_req_t;

    // register bank write, used by core and controller alike
    typedef struct packed {
        logic [rtos_cfg_pkg::REG_ADDR_W-1:0] addr;
        logic [rtos_cfg_pkg::XLEN-1:0]       data;
    } rf_wr_t;

endpackage

// ==== rtl/rtos_cfg_pkg.sv ====
package rtos_cfg_pkg;

    // datapath and id widths
    localparam int XLEN       = 32;  // data word
    localparam int ADDR_W     = 32;  // byte address toward context memory
    localparam int TASK_ID_W  = 3;   // caps the table at 8 tasks
    localparam int PRIO_W     = 4;   // larger value wins
    localparam int REG_ADDR_W = 5;   // cold register index from the core

    // frame layout
    // cold regs first, then the csr words
    localparam int CSR_WORDS   = 2;
    localparam int MEPC_OFS    = 0;  // offset past the last cold reg
    localparam int MSTATUS_OFS = 1;
    localparam int WORD_SHIFT  = 2;  // 4 bytes per frame word

    // custom instruction, carried in funct3
    typedef enum logic [2:0] {
        OP_CREATE  = 3'd0,  // id, prio -> 1 on success
        OP_DELETE  = 3'd1,  // id -> 0
        OP_GET_CUR = 3'd2   // -> running task id
    } cust_op_e;

    // words per saved frame for a given cold bank size
    function automatic int frame_words(input int num_cold);
        return num_cold + CSR_WORDS;
    endfunction

endpackage
